//--- design/video_pkg.sv
`default_nettype none
/* shared widths and types for the video timing core
   imported by every design module and by the testbench */

package video_pkg;

	// beam position, horizontal or vertical
	typedef logic [9:0] coord_t;

	// host register port
	typedef logic [7:0] reg_addr_t;	// byte address into the bank
	typedef logic [7:0] reg_data_t;	// one register

	typedef logic [15:0] frame_ctr_t;	// wraps silently
	typedef logic [3:0]  div_t;	// pixel divider phase

	// raster trigger slots
	localparam int NUM_TRIGGERS = 24;

	// slot i: bit 2i horizontal hit, bit 2i+1 vertical hit
	typedef logic [2*NUM_TRIGGERS-1:0] trig_vec_t;

	// one bit per slot, lsb is slot 0
	typedef logic [NUM_TRIGGERS-1:0] irq_mask_t;

endpackage

`default_nettype wire

//--- design/hw_ctrl_regs.sv
`timescale 1ns/10ps
`default_nettype none
/* host register bank behind a four-phase req/ack port
   holds trigger positions, irq enables and the write-only clear strobes */

module hw_ctrl_regs #(
	parameter int REGS_SIZE   = 8,	// address width, must cover the map
	parameter int BASE_OFFSET = 32	// first trigger slot register
) (
	input  wire                           pclk,
	input  wire                           reset,
	input  wire                           host_req,
	input  wire                           host_we,
	input  wire video_pkg::reg_addr_t     host_addr,
	input  wire video_pkg::reg_data_t     host_wdata,
	output logic                          host_ack,
	output video_pkg::reg_data_t          host_rdata,
	output logic [video_pkg::NUM_TRIGGERS*$bits(video_pkg::coord_t)-1:0] trigger_pos_h,
	output logic [video_pkg::NUM_TRIGGERS*$bits(video_pkg::coord_t)-1:0] trigger_pos_v,
	output video_pkg::irq_mask_t          irq_enable,
	output video_pkg::irq_mask_t          irq_clear
);
	import video_pkg::*;

	localparam int DEPTH    = 2**REGS_SIZE;
	localparam int CW       = $bits(coord_t);
	localparam int EN_BASE  = BASE_OFFSET + 4*NUM_TRIGGERS;	// three enable bytes
	localparam int CLR_BASE = EN_BASE + 3;	// three clear bytes

	typedef enum logic [1:0] {ST_IDLE, ST_ACK, ST_WAIT_REQ_LOW} state_t;

	state_t               state;
	reg_data_t            regs [0:DEPTH-1];
	logic [REGS_SIZE-1:0] idx;
	logic                 is_clr;	// address hits a clear register

	assign idx    = host_addr[REGS_SIZE-1:0];
	assign is_clr = (int'(host_addr) >= CLR_BASE) && (int'(host_addr) < CLR_BASE + 3);

	// handshake and register access
	always_ff @(posedge pclk)
	begin
		irq_clear <= '0;	// one-cycle strobe
		if (reset)
		begin
			state    <= ST_IDLE;
			host_ack <= 1'b0;
			for (int a = 0; a < DEPTH; a++)
				regs[a] <= '0;
		end
		else
		begin
			case (state)
			ST_IDLE:
				if (host_req)	// new access with ack low
				begin
					host_ack   <= 1'b1;
					state      <= ST_ACK;
					host_rdata <= regs[idx];	// clear regs are never stored so read as zero
					if (host_we && is_clr)
					begin
						for (int k = 0; k < 3; k++)
							if (int'(host_addr) == CLR_BASE + k)
								irq_clear[k*8 +: 8] <= host_wdata;
					end
					else if (host_we)
						regs[idx] <= host_wdata;
				end
			ST_ACK:
			begin
				host_ack <= host_req;	// host may already have dropped req
				state    <= host_req ? ST_WAIT_REQ_LOW : ST_IDLE;
			end
			ST_WAIT_REQ_LOW:
				if (!host_req)
				begin
					host_ack <= 1'b0;
					state    <= ST_IDLE;
				end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// pack high/low bytes into coordinates for the compare logic
	always_comb
	begin
		for (int i = 0; i < NUM_TRIGGERS; i++)
		begin
			trigger_pos_h[i*CW +: CW] = {regs[BASE_OFFSET + 4*i][1:0], regs[BASE_OFFSET + 4*i + 1]};
			trigger_pos_v[i*CW +: CW] = {regs[BASE_OFFSET + 4*i + 2][1:0], regs[BASE_OFFSET + 4*i + 3]};
		end
	end

	assign irq_enable = {regs[EN_BASE + 2], regs[EN_BASE + 1], regs[EN_BASE]};	// slot 0 in lsb

endmodule

`default_nettype wire

//--- design/sync_generator.sv
`timescale 1ns/10ps
`default_nettype none
/* raster timing: pixel enable, beam counters, sync/display enables,
   frame counter and raster trigger compare against packed slot positions */

module sync_generator #(
	parameter int H_RES           = 640,
	parameter int V_RES           = 480,
	parameter int IMAGE_OFFSET_X  = 16,	// room for objects left of the screen
	parameter int IMAGE_OFFSET_Y  = 16,
	parameter int H_FRONT_PORCH   = 16,
	parameter int HSYNC_WIDTH     = 96,
	parameter int H_BACK_PORCH    = 48,
	parameter int V_FRONT_PORCH   = 10,
	parameter int VSYNC_HEIGHT    = 2,
	parameter int V_BACK_PORCH    = 33,
	parameter int PIX_CLK_DIVIDER = 4	// pixel lasts PIX_CLK_DIVIDER+1 clocks
) (
	input  wire                         pclk,
	input  wire                         reset,
	input  wire [video_pkg::NUM_TRIGGERS*$bits(video_pkg::coord_t)-1:0] trigger_pos_h,
	input  wire [video_pkg::NUM_TRIGGERS*$bits(video_pkg::coord_t)-1:0] trigger_pos_v,
	output logic                        pix_tick,
	output logic                        hsync,
	output logic                        vsync,
	output logic                        hde,
	output logic                        vde,
	output video_pkg::frame_ctr_t       frame_ctr,
	output video_pkg::trig_vec_t        raster_triggers
);
	import video_pkg::*;

	localparam int CW        = $bits(coord_t);
	localparam int LINE      = H_RES + H_FRONT_PORCH + HSYNC_WIDTH + H_BACK_PORCH;
	localparam int SCANLINES = V_RES + V_FRONT_PORCH + VSYNC_HEIGHT + V_BACK_PORCH;

	// event points, wrapped into the line/frame so small screens still work
	// hsync points are one pixel early since hsync is registered
	localparam coord_t HS_STA = coord_t'((IMAGE_OFFSET_X + H_RES + H_FRONT_PORCH - 1) % LINE);
	localparam coord_t HS_END =
		coord_t'((IMAGE_OFFSET_X + H_RES + H_FRONT_PORCH + HSYNC_WIDTH - 1) % LINE);
	localparam coord_t VS_STA = coord_t'((IMAGE_OFFSET_Y + V_RES + V_FRONT_PORCH) % SCANLINES);
	localparam coord_t VS_END =
		coord_t'((IMAGE_OFFSET_Y + V_RES + V_FRONT_PORCH + VSYNC_HEIGHT) % SCANLINES);
	localparam coord_t HDE_STA = coord_t'(IMAGE_OFFSET_X % LINE);
	localparam coord_t HDE_END = coord_t'((IMAGE_OFFSET_X + H_RES) % LINE);
	localparam coord_t VDE_STA = coord_t'(IMAGE_OFFSET_Y % SCANLINES);
	localparam coord_t VDE_END = coord_t'((IMAGE_OFFSET_Y + V_RES) % SCANLINES);
	localparam coord_t H_LAST  = coord_t'(LINE - 1);
	localparam coord_t V_LAST  = coord_t'(SCANLINES - 1);

	div_t   div;	// pixel divider phase
	coord_t h_count;	// beam x
	coord_t v_count;	// beam y

	assign pix_tick = (div == '0);

	// pixel clock divider
	always_ff @(posedge pclk)
	begin
		if (reset)
			div <= '0;	// known phase after reset
		else if (div == div_t'(PIX_CLK_DIVIDER))
			div <= '0;
		else
			div <= div + 1'b1;
	end

	always_ff @(posedge pclk)
	begin
		if (reset)	// restart two pixels before end of visible line, near frame end
		begin
			h_count         <= coord_t'(IMAGE_OFFSET_X + H_RES - 2);
			v_count         <= coord_t'(SCANLINES - 2);
			hsync           <= 1'b0;
			vsync           <= 1'b0;
			hde             <= 1'b0;
			vde             <= 1'b0;
			frame_ctr       <= '0;
			raster_triggers <= '0;
		end
		else if (pix_tick)	// once per pixel
		begin
			// horizontal hits, one pixel wide
			for (int i = 0; i < NUM_TRIGGERS; i++)
				raster_triggers[2*i] <= (h_count == trigger_pos_h[i*CW +: CW]);

			if (h_count == HDE_STA)
				hde <= 1'b1;
			else if (h_count == HDE_END)
				hde <= 1'b0;

			if (h_count == HS_STA)
				hsync <= 1'b1;
			else if (h_count == HS_END)
				hsync <= 1'b0;

			if (v_count == VS_STA)
				vsync <= 1'b1;
			else if (v_count == VS_END)
				vsync <= 1'b0;

			if (h_count == H_LAST)	// end of line
			begin
				h_count <= '0;

				// vertical hits, held for a whole line
				for (int i = 0; i < NUM_TRIGGERS; i++)
					raster_triggers[2*i+1] <= (v_count == trigger_pos_v[i*CW +: CW]);

				if (v_count == VDE_STA)
					vde <= 1'b1;
				else if (v_count == VDE_END)
					vde <= 1'b0;

				if (v_count == V_LAST)	// end of frame
				begin
					v_count   <= '0;
					frame_ctr <= frame_ctr + 1'b1;
				end
				else
					v_count <= v_count + 1'b1;
			end
			else
				h_count <= h_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/raster_irq.sv
`timescale 1ns/10ps
`default_nettype none
/* raster interrupt unit: latches enabled vertical triggers as sticky
   pending bits, cleared by the register bank strobe; drives one irq line */

module raster_irq (
	input  wire                        pclk,
	input  wire                        reset,
	input  wire                        pix_tick,
	input  wire video_pkg::trig_vec_t  raster_triggers,
	input  wire video_pkg::irq_mask_t  irq_enable,
	input  wire video_pkg::irq_mask_t  irq_clear,
	output video_pkg::irq_mask_t       irq_pending,
	output logic                       irq
);
	import video_pkg::*;

	irq_mask_t v_trig;	// vertical bit of each slot
	irq_mask_t set_mask;

	// pick odd bits out of the trigger vector
	always_comb
	begin
		for (int i = 0; i < NUM_TRIGGERS; i++)
			v_trig[i] = raster_triggers[2*i+1];
	end

	// sampled on pixel enable only, trigger bits move with the beam
	assign set_mask = pix_tick ? (v_trig & irq_enable) : '0;

	always_ff @(posedge pclk)
	begin
		if (reset)
		begin
			irq_pending <= '0;
			irq         <= 1'b0;
		end
		else
		begin
			irq_pending <= (irq_pending & ~irq_clear) | set_mask;	// set beats clear
			irq         <= |irq_pending;	// one cycle behind pending
		end
	end

endmodule

`default_nettype wire

//--- design/video_timing_top.sv
`timescale 1ns/10ps
`default_nettype none
/* video timing core top: register bank, sync generator and raster irq
   all screen, porch and divider parameters enter here */

module video_timing_top #(
	parameter int H_RES           = 640,
	parameter int V_RES           = 480,
	parameter int IMAGE_OFFSET_X  = 16,
	parameter int IMAGE_OFFSET_Y  = 16,
	parameter int H_FRONT_PORCH   = 16,
	parameter int HSYNC_WIDTH     = 96,
	parameter int H_BACK_PORCH    = 48,
	parameter int V_FRONT_PORCH   = 10,
	parameter int VSYNC_HEIGHT    = 2,
	parameter int V_BACK_PORCH    = 33,
	parameter int PIX_CLK_DIVIDER = 4,
	parameter int REGS_SIZE       = 8,
	parameter int BASE_OFFSET     = 32
) (
	input  wire                        pclk,
	input  wire                        reset,
	input  wire                        host_req,
	input  wire                        host_we,
	input  wire video_pkg::reg_addr_t  host_addr,
	input  wire video_pkg::reg_data_t  host_wdata,
	output wire                        host_ack,
	output wire video_pkg::reg_data_t  host_rdata,
	output wire                        hsync,
	output wire                        vsync,
	output wire                        hde,
	output wire                        vde,
	output wire video_pkg::frame_ctr_t frame_ctr,
	output wire video_pkg::trig_vec_t  raster_triggers,
	output wire                        pix_tick,
	output wire video_pkg::irq_mask_t  irq_pending,
	output wire                        irq
);
	import video_pkg::*;

	localparam int POS_W = NUM_TRIGGERS * $bits(coord_t);	// 24 packed coordinates

	wire [POS_W-1:0] trigger_pos_h;
	wire [POS_W-1:0] trigger_pos_v;
	irq_mask_t       irq_enable;
	irq_mask_t       irq_clear;	// one-cycle strobe from the bank

	hw_ctrl_regs #(
		.REGS_SIZE   (REGS_SIZE),
		.BASE_OFFSET (BASE_OFFSET)
	) u_regs (
		.pclk          (pclk),
		.reset         (reset),
		.host_req      (host_req),
		.host_we       (host_we),
		.host_addr     (host_addr),
		.host_wdata    (host_wdata),
		.host_ack      (host_ack),
		.host_rdata    (host_rdata),
		.trigger_pos_h (trigger_pos_h),
		.trigger_pos_v (trigger_pos_v),
		.irq_enable    (irq_enable),
		.irq_clear     (irq_clear)
	);

	sync_generator #(
		.H_RES           (H_RES),
		.V_RES           (V_RES),
		.IMAGE_OFFSET_X  (IMAGE_OFFSET_X),
		.IMAGE_OFFSET_Y  (IMAGE_OFFSET_Y),
		.H_FRONT_PORCH   (H_FRONT_PORCH),
		.HSYNC_WIDTH     (HSYNC_WIDTH),
		.H_BACK_PORCH    (H_BACK_PORCH),
		.V_FRONT_PORCH   (V_FRONT_PORCH),
		.VSYNC_HEIGHT    (VSYNC_HEIGHT),
		.V_BACK_PORCH    (V_BACK_PORCH),
		.PIX_CLK_DIVIDER (PIX_CLK_DIVIDER)
	) u_sync (
		.pclk            (pclk),
		.reset           (reset),
		.trigger_pos_h   (trigger_pos_h),
		.trigger_pos_v   (trigger_pos_v),
		.pix_tick        (pix_tick),
		.hsync           (hsync),
		.vsync           (vsync),
		.hde             (hde),
		.vde             (vde),
		.frame_ctr       (frame_ctr),
		.raster_triggers (raster_triggers)
	);

	raster_irq u_irq (
		.pclk            (pclk),
		.reset           (reset),
		.pix_tick        (pix_tick),
		.raster_triggers (raster_triggers),
		.irq_enable      (irq_enable),
		.irq_clear       (irq_clear),
		.irq_pending     (irq_pending),
		.irq             (irq)
	);

endmodule

`default_nettype wire

//--- dv/tb_video_timing.sv
`timescale 1ns/10ps
`default_nettype none
/* directed testbench for the video timing core on a tiny 16x8 screen
   covers host access, pixel enable, sync timing, frame count, raster triggers and irq */

module tb_video_timing;
	import video_pkg::*;

	localparam int H_RES = 16;
	localparam int V_RES = 8;
	localparam int OFS_X = 2;
	localparam int OFS_Y = 2;
	localparam int HFP   = 2;
	localparam int HSW   = 3;
	localparam int HBP   = 2;
	localparam int VFP   = 1;
	localparam int VSH   = 1;
	localparam int VBP   = 1;
	localparam int DIV   = 1;	// two clocks per pixel
	localparam int LINE      = H_RES + HFP + HSW + HBP;	// pixels per line
	localparam int SCANLINES = V_RES + VFP + VSH + VBP;
	localparam int FRAME_CLKS = LINE * SCANLINES * (DIV + 1);
	localparam int BASE     = 32;
	localparam int EN_ADDR  = BASE + 4*NUM_TRIGGERS;	// three enable bytes
	localparam int CLR_ADDR = EN_ADDR + 3;	// three clear bytes
	localparam int SLOT     = 5;
	localparam int ACK_TIMEOUT = 32;	// clocks
	localparam int SEL_HSYNC = 0;
	localparam int SEL_HDE   = 1;
	localparam int SEL_VSYNC = 2;
	localparam int SEL_VDE   = 3;

	logic       pclk;
	logic       reset;
	logic       host_req;
	logic       host_we;
	reg_addr_t  host_addr;
	reg_data_t  host_wdata;
	wire        host_ack;
	reg_data_t  host_rdata;
	wire        hsync;
	wire        vsync;
	wire        hde;
	wire        vde;
	frame_ctr_t frame_ctr;
	trig_vec_t  raster_triggers;
	wire        pix_tick;
	irq_mask_t  irq_pending;
	wire        irq;
	integer     seed;

	video_timing_top #(
		.H_RES (H_RES), .V_RES (V_RES), .IMAGE_OFFSET_X (OFS_X), .IMAGE_OFFSET_Y (OFS_Y),
		.H_FRONT_PORCH (HFP), .HSYNC_WIDTH (HSW), .H_BACK_PORCH (HBP),
		.V_FRONT_PORCH (VFP), .VSYNC_HEIGHT (VSH), .V_BACK_PORCH (VBP),
		.PIX_CLK_DIVIDER (DIV), .REGS_SIZE (8), .BASE_OFFSET (BASE)
	) u_dut (
		.pclk (pclk), .reset (reset), .host_req (host_req), .host_we (host_we),
		.host_addr (host_addr), .host_wdata (host_wdata), .host_ack (host_ack),
		.host_rdata (host_rdata), .hsync (hsync), .vsync (vsync), .hde (hde), .vde (vde),
		.frame_ctr (frame_ctr), .raster_triggers (raster_triggers), .pix_tick (pix_tick),
		.irq_pending (irq_pending), .irq (irq)
	);

	initial
	begin
		pclk = 1'b0;
		forever #4 pclk = ~pclk;	// 8 ns period
	end

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
		if (got !== exp)
			stop_with_error($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_frame(input string name, input frame_ctr_t got, input frame_ctr_t exp);
		if (got !== exp)
			stop_with_error($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_mask(input string name, input irq_mask_t got, input irq_mask_t exp);
		if (got !== exp)
			stop_with_error($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got !== exp)
			stop_with_error($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	function automatic logic video_sig(input int sel);
		case (sel)
		SEL_HSYNC: return hsync;
		SEL_HDE:   return hde;
		SEL_VSYNC: return vsync;
		default:   return vde;
		endcase
	endfunction

	// step to the next negedge where pix_tick is high
	task automatic next_pixel();
		int n;
		n = 0;
		do
		begin
			@(negedge pclk);
			n++;
		end
		while (!pix_tick && n < 4*(DIV + 1));
		if (!pix_tick)
			stop_with_error("pixel enable never came");
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		do
		begin
			@(negedge pclk);
			n++;
		end
		while (host_ack !== level && n < ACK_TIMEOUT);
		if (host_ack !== level)
			stop_with_error($sformatf("host_ack stuck, never went to %0b", level));
	endtask

	// four-phase handshake on req and ack
	task automatic host_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
		output reg_data_t rdata);
		@(posedge pclk);
		host_req   <= 1'b1;
		host_we    <= we;
		host_addr  <= addr;
		host_wdata <= wdata;
		wait_ack(1'b1);
		rdata = host_rdata;	// valid while ack high
		@(posedge pclk);
		host_req <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic host_write(input int addr, input reg_data_t data);
		reg_data_t unused;
		host_access(1'b1, reg_addr_t'(addr), data, unused);
	endtask

	task automatic host_read(input int addr, output reg_data_t data);
		host_access(1'b0, reg_addr_t'(addr), '0, data);
	endtask

	task automatic program_slot(input int slot, input coord_t ph, input coord_t pv);
		host_write(BASE + 4*slot, reg_data_t'(ph[9:8]));	// high regs hold 2 bits
		host_write(BASE + 4*slot + 1, ph[7:0]);
		host_write(BASE + 4*slot + 2, reg_data_t'(pv[9:8]));
		host_write(BASE + 4*slot + 3, pv[7:0]);
	endtask

	// rising edge of a video signal sampled per pixel
	task automatic wait_pixel_rise(input int sel, input int limit, output int pixels);
		logic prev;
		logic cur;
		cur    = video_sig(sel);
		pixels = 0;
		do
		begin
			prev = cur;
			next_pixel();
			cur = video_sig(sel);
			pixels++;
		end
		while (!(cur && !prev) && pixels < limit);
		if (!(cur && !prev))
			stop_with_error($sformatf("video signal %0d never rose", sel));
	endtask

	task automatic pixel_run(input int sel, output int len);
		int px;
		wait_pixel_rise(sel, 2*LINE, px);
		len = 0;
		while (video_sig(sel) && len <= LINE)
		begin
			len++;
			next_pixel();
		end
	endtask

	// line-rate version sampled at each hsync rise
	task automatic wait_line_rise(input int sel);
		logic prev;
		logic cur;
		int   lines;
		int   px;
		cur   = video_sig(sel);
		lines = 0;
		do
		begin
			prev = cur;
			wait_pixel_rise(SEL_HSYNC, 2*LINE, px);
			cur = video_sig(sel);
			lines++;
		end
		while (!(cur && !prev) && lines < 2*SCANLINES);
		if (!(cur && !prev))
			stop_with_error($sformatf("video signal %0d never rose at line rate", sel));
	endtask

	task automatic line_run(input int sel, output int len);
		int px;
		wait_line_rise(sel);
		len = 0;
		while (video_sig(sel) && len <= SCANLINES)
		begin
			len++;
			wait_pixel_rise(SEL_HSYNC, 2*LINE, px);
		end
	endtask

	task automatic test_registers();
		reg_data_t model [0:255];
		reg_addr_t addrs [$];
		int        a;
		reg_data_t d;
		for (int i = 0; i < 12; i++)
		begin
			if (i < 9)
				a = BASE + int'($unsigned($random(seed)) % (4*NUM_TRIGGERS));	// slot regs
			else
				a = EN_ADDR + i - 9;	// the enable bytes
			d = reg_data_t'($random(seed));
			host_write(a, d);
			model[a] = d;
			addrs.push_back(reg_addr_t'(a));
		end
		foreach (addrs[i])
		begin
			host_read(addrs[i], d);
			check_data($sformatf("reg 0x%0h", addrs[i]), d, model[addrs[i]]);
		end
		host_write(CLR_ADDR, reg_data_t'($random(seed)) | 8'h01);	// never an all-zero write
		host_read(CLR_ADDR, d);
		check_data("clear reg readback", d, '0);	// write-only strobe
		foreach (addrs[i])
			host_write(addrs[i], '0);	// slots and enables back to 0
	endtask

	// one pixel enable in every DIV+1 clocks
	task automatic test_pixel_enable();
		int n;
		next_pixel();
		repeat (4)
		begin
			n = 0;
			do
			begin
				@(negedge pclk);
				n++;
			end
			while (!pix_tick && n < 4*(DIV + 1));
			check_count("pix_tick period", n, DIV + 1);
		end
	endtask

	task automatic test_horizontal();
		int len;
		wait_pixel_rise(SEL_HSYNC, 2*LINE, len);
		wait_pixel_rise(SEL_HSYNC, 2*LINE, len);
		check_count("hsync period", len, LINE);
		pixel_run(SEL_HSYNC, len);
		check_count("hsync width", len, HSW);
		pixel_run(SEL_HDE, len);
		check_count("hde width", len, H_RES);
	endtask

	task automatic test_vertical();
		int         len;
		frame_ctr_t start;
		frame_ctr_t prev;
		line_run(SEL_VSYNC, len);
		check_count("vsync height", len, VSH);
		line_run(SEL_VDE, len);
		check_count("vde height", len, V_RES);
		wait_line_rise(SEL_VSYNC);
		start = frame_ctr;
		prev  = start;
		repeat (3)
		begin
			wait_line_rise(SEL_VSYNC);
			check_frame("frame_ctr step", frame_ctr, frame_ctr_t'(prev + 1));
			prev = frame_ctr;
		end
		check_frame("frame_ctr after 3 frames", frame_ctr, frame_ctr_t'(start + 3));
	endtask

	task automatic test_triggers();
		coord_t ph;
		coord_t pv;
		int     col;
		int     hits;
		int     px;
		ph = coord_t'($unsigned($random(seed)) % LINE);
		pv = coord_t'($unsigned($random(seed)) % SCANLINES);
		program_slot(SLOT, ph, pv);
		// hsync falls at beam x OFS_X+H_RES+HFP+HSW
		// trigger flop lags the beam by one pixel
		col = (int'(ph) - (OFS_X + H_RES + HFP + HSW) + 1 + 2*LINE) % LINE;
		pixel_run(SEL_HSYNC, px);	// now on the first pixel after the fall
		repeat (3)
		begin
			hits = 0;
			for (int k = 0; k < LINE; k++)
			begin
				if (raster_triggers[2*SLOT])
				begin
					hits++;
					check_count("h trigger column", k, col);
				end
				next_pixel();
			end
			check_count("h trigger pixels per line", hits, 1);
		end
		hits = 0;
		repeat (SCANLINES)	// one sample per line
		begin
			wait_pixel_rise(SEL_HSYNC, 2*LINE, px);
			if (raster_triggers[2*SLOT+1])
				hits++;
		end
		check_count("v trigger lines per frame", hits, 1);
	endtask

	task automatic test_irq();
		int n;
		int px;
		for (int k = 0; k < 3; k++)
			host_write(CLR_ADDR + k, 8'hff);	// drop stale pending bits
		check_mask("irq_pending after clear all", irq_pending, '0);
		program_slot(SLOT, '0, coord_t'(V_RES/2));	// trigger line far from vsync
		host_write(EN_ADDR, reg_data_t'(1 << SLOT));
		n = 0;
		while (!irq && n < 2*FRAME_CLKS)
		begin
			@(negedge pclk);
			n++;
		end
		if (!irq)
			stop_with_error("irq never rose with slot 5 enabled");
		check_mask("irq_pending", irq_pending, irq_mask_t'(1) << SLOT);
		wait_pixel_rise(SEL_VSYNC, 2*LINE*SCANLINES, px);
		host_write(CLR_ADDR, reg_data_t'(1 << SLOT));
		check_mask("irq_pending after clear", irq_pending, '0);
		check_count("irq after clear", int'(irq), 0);
		host_write(EN_ADDR, '0);
		repeat (FRAME_CLKS + LINE)	// watch a bit more than one frame
		begin
			@(negedge pclk);
			if (irq)
				stop_with_error("irq rose with slot 5 disabled");
		end
	endtask

	initial
	begin
		seed       = 36;
		reset      = 1'b1;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		repeat (5) @(posedge pclk);
		reset <= 1'b0;
		test_registers();
		test_pixel_enable();
		test_horizontal();
		test_vertical();
		test_triggers();
		test_irq();
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
design/video_pkg.sv
design/hw_ctrl_regs.sv
design/sync_generator.sv
design/raster_irq.sv
design/video_timing_top.sv
dv/tb_video_timing.sv

//--- Makefile
# Verilator build and run of the video timing testbench
VERILATOR ?= verilator
TOP       ?= tb_video_timing
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
